// ==== rtl/hisPkg.sv ====
package hisPkg;

    // raw pixel sample width
    localparam int PixelWidth = 10;
    // bin counters and sample count, saturating at all ones
    localparam int CountWidth = 16;
    // wishbone data bus width
    localparam int DataWidth = 32;

    // one beat of the pixel stream
    typedef struct packed {
        logic                  valid;
        logic [PixelWidth-1:0] value;
    } sample_t;

    // range result of the running acquisition
    typedef struct packed {
        logic [PixelWidth-1:0] minValue;
        logic [PixelWidth-1:0] maxValue;
        logic [CountWidth-1:0] sampleCount;
    } rangeStats_t;

    typedef enum logic {
        acqIdle = 1'b0,
        acqRun  = 1'b1
    } acqState_t;

    // opcodes written to the control register
    typedef enum logic [1:0] {
        cmdNop   = 2'd0,
        cmdStart = 2'd1,
        cmdStop  = 2'd2,
        cmdClear = 2'd3
    } acqCmd_t;

    // word addresses of the register map, bin k sits at regBinBase + k
    typedef enum logic [7:0] {
        regCtrl    = 8'd0,
        regStatus  = 8'd1,
        regMin     = 8'd2,
        regMax     = 8'd3,
        regCount   = 8'd4,
        regBinBase = 8'd16
    } regAddr_t;

endpackage

// ==== rtl/hisBinCounter.sv ====
`timescale 1ns/1ns

module hisBinCounter import hisPkg::*; #(
    parameter int numBinBits = 3
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    countEnable,
    input  logic    clearStats,
    input  sample_t sampleIn,
    output logic [2**numBinBits-1:0][CountWidth-1:0] binCounts
);

    localparam int numBins = 2**numBinBits;

    logic                  sampleAccept;
    logic [numBinBits-1:0] binIdx;
    logic [numBins-1:0]    binHit;
    logic [numBins-1:0]    binFull;

    // samples only count while an acquisition runs
    assign sampleAccept = countEnable & sampleIn.valid;

    // equal width bins, so the bin is just the msbs of the value
    assign binIdx = sampleIn.value[PixelWidth-1 -: numBinBits];

    always_comb begin
        for (int k = 0; k < numBins; k++) begin
            binHit[k]  = sampleAccept && (binIdx == numBinBits'(k));
            binFull[k] = &binCounts[k];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            binCounts <= '0;
        end else if (clearStats) begin
            // a sample on the clear edge is dropped
            binCounts <= '0;
        end else begin
            for (int k = 0; k < numBins; k++) begin
                // hold at all ones once the counter is full
                if (binHit[k] && !binFull[k]) begin
                    binCounts[k] <= binCounts[k] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/hisRangeTracker.sv ====
`timescale 1ns/1ns

module hisRangeTracker import hisPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        countEnable,
    input  logic        clearStats,
    input  sample_t     sampleIn,
    output rangeStats_t rangeStats
);

    logic sampleAccept;
    logic newMin;
    logic newMax;
    logic countFull;

    assign sampleAccept = countEnable & sampleIn.valid;

    // compare against the stored extremes, min starts at all ones
    assign newMin    = sampleIn.value < rangeStats.minValue;
    assign newMax    = sampleIn.value > rangeStats.maxValue;
    assign countFull = &rangeStats.sampleCount;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rangeStats.minValue    <= '1;
            rangeStats.maxValue    <= '0;
            rangeStats.sampleCount <= '0;
        end else if (clearStats) begin
            rangeStats.minValue    <= '1;
            rangeStats.maxValue    <= '0;
            rangeStats.sampleCount <= '0;
        end else if (sampleAccept) begin
            if (newMin) begin
                rangeStats.minValue <= sampleIn.value;
            end
            if (newMax) begin
                rangeStats.maxValue <= sampleIn.value;
            end
            // saturating sample count
            if (!countFull) begin
                rangeStats.sampleCount <= rangeStats.sampleCount + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/hisReadout.sv ====
`timescale 1ns/1ns

module hisReadout import hisPkg::*; #(
    parameter int numBinBits = 3
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [7:0]           wbAdr,
    input  logic [DataWidth-1:0] wbDatW,
    input  logic [2**numBinBits-1:0][CountWidth-1:0] binCounts,
    input  rangeStats_t          rangeStats,
    output logic [DataWidth-1:0] wbDatR,
    output logic                 wbAck,
    output logic                 countEnable,
    output logic                 clearStats
);

    localparam int numBins = 2**numBinBits;

    acqState_t            acqState;
    acqCmd_t              ctrlCmd;
    logic                 busAccess;
    logic                 ctrlWrite;
    logic                 cmdValid;
    logic [7:0]           binOffset;
    logic                 binInRange;
    logic [DataWidth-1:0] readData;

    // one access per request, ack drops again after a single cycle
    assign busAccess = wbCyc & wbStb & ~wbAck;
    assign ctrlWrite = busAccess & wbWe & (wbAdr == regCtrl);

    // opcodes above cmdClear are not commands at all
    assign ctrlCmd  = acqCmd_t'(wbDatW[1:0]);
    assign cmdValid = (wbDatW[DataWidth-1:2] == '0);

    // clear lands on the same edge as the ack
    assign clearStats  = ctrlWrite & cmdValid & (ctrlCmd == cmdClear);
    assign countEnable = (acqState == acqRun);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck    <= 1'b0;
            acqState <= acqIdle;
        end else begin
            wbAck <= busAccess;
            if (ctrlWrite && cmdValid) begin
                case (ctrlCmd)
                    cmdStart: acqState <= acqRun;
                    cmdStop:  acqState <= acqIdle;
                    default:  acqState <= acqState;
                endcase
            end
        end
    end

    // bin window starts at regBinBase
    assign binOffset  = wbAdr - regBinBase;
    assign binInRange = (wbAdr >= regBinBase) && (int'(binOffset) < numBins);

    always_comb begin
        readData = '0;
        case (wbAdr)
            regStatus: readData[0] = (acqState == acqRun);
            regMin:    readData = DataWidth'(rangeStats.minValue);
            regMax:    readData = DataWidth'(rangeStats.maxValue);
            regCount:  readData = DataWidth'(rangeStats.sampleCount);
            default: begin
                // regCtrl and holes in the map stay zero
                if (binInRange) begin
                    readData = DataWidth'(binCounts[binOffset[numBinBits-1:0]]);
                end
            end
        endcase
    end

    // read data is captured together with the ack
    always_ff @(posedge clk) begin
        if (busAccess && !wbWe) begin
            wbDatR <= readData;
        end
    end

endmodule

// ==== rtl/hisBuilderTop.sv ====
`timescale 1ns/1ns

module hisBuilderTop import hisPkg::*; #(
    parameter int numBinBits = 3
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  sample_t              sampleIn,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [7:0]           wbAdr,
    input  logic [DataWidth-1:0] wbDatW,
    output logic [DataWidth-1:0] wbDatR,
    output logic                 wbAck
);

    logic                                     countEnable;
    logic                                     clearStats;
    logic [2**numBinBits-1:0][CountWidth-1:0] binCounts;
    rangeStats_t                              rangeStats;

    // both blocks see every beat and gate it themselves
    hisBinCounter #(
        .numBinBits (numBinBits)
    ) i_hisBinCounter (
        .clk         (clk),
        .arstN       (arstN),
        .countEnable (countEnable),
        .clearStats  (clearStats),
        .sampleIn    (sampleIn),
        .binCounts   (binCounts)
    );

    hisRangeTracker i_hisRangeTracker (
        .clk         (clk),
        .arstN       (arstN),
        .countEnable (countEnable),
        .clearStats  (clearStats),
        .sampleIn    (sampleIn),
        .rangeStats  (rangeStats)
    );

    // host side, run control and register map
    hisReadout #(
        .numBinBits (numBinBits)
    ) i_hisReadout (
        .clk         (clk),
        .arstN       (arstN),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbAdr       (wbAdr),
        .wbDatW      (wbDatW),
        .binCounts   (binCounts),
        .rangeStats  (rangeStats),
        .wbDatR      (wbDatR),
        .wbAck       (wbAck),
        .countEnable (countEnable),
        .clearStats  (clearStats)
    );

endmodule

// ==== dv/hisBuilderTb.sv ====
`timescale 1ns/1ns

module hisBuilderTb import hisPkg::*; ();

    localparam int numBinBits = 3;
    localparam int ackTimeout = 20;
    // upper bound on operations taken from the pattern file
    localparam int maxOps = 1000;

    logic                 clk;
    logic                 arstN;
    sample_t              sampleIn;
    logic                 wbCyc;
    logic                 wbStb;
    logic                 wbWe;
    logic [7:0]           wbAdr;
    logic [DataWidth-1:0] wbDatW;
    logic [DataWidth-1:0] wbDatR;
    logic                 wbAck;

    int readChecks;
    int compareErrors;
    int timeoutErrors;
    int otherErrors;
    int patternFd;

    hisBuilderTop #(
        .numBinBits (numBinBits)
    ) i_hisBuilderTop (
        .clk      (clk),
        .arstN    (arstN),
        .sampleIn (sampleIn),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatW   (wbDatW),
        .wbDatR   (wbDatR),
        .wbAck    (wbAck)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // one valid beat, held for a single cycle
    task automatic offerSample(input logic [PixelWidth-1:0] value);
        sampleIn.valid = 1'b1;
        sampleIn.value = value;
        @(negedge clk);
        sampleIn.valid = 1'b0;
    endtask

    task automatic idleCycle(input logic [PixelWidth-1:0] value);
        sampleIn.valid = 1'b0;
        sampleIn.value = value;
        @(negedge clk);
    endtask

    // classic single access, request held until ack is seen
    task automatic wishboneAccess(
        input  logic                 we,
        input  logic [7:0]           adr,
        input  logic [DataWidth-1:0] writeData,
        output logic [DataWidth-1:0] readData,
        output logic                 acked
    );
        int waitCycles;
        wbCyc      = 1'b1;
        wbStb      = 1'b1;
        wbWe       = we;
        wbAdr      = adr;
        wbDatW     = writeData;
        acked      = 1'b0;
        waitCycles = 0;
        while (!acked && waitCycles < ackTimeout) begin
            @(negedge clk);
            waitCycles++;
            acked = (wbAck === 1'b1);
        end
        readData = wbDatR;
        wbCyc    = 1'b0;
        wbStb    = 1'b0;
        wbWe     = 1'b0;
        if (!acked) begin
            $display("Wishbone ack never arrived at word address %0d", adr);
            timeoutErrors++;
        end
    endtask

    task automatic writeRegister(input logic [7:0] adr, input logic [DataWidth-1:0] data);
        logic [DataWidth-1:0] unusedData;
        logic                 acked;
        wishboneAccess(1'b1, adr, data, unusedData, acked);
    endtask

    task automatic checkRead(input logic [7:0] adr, input logic [DataWidth-1:0] expected);
        logic [DataWidth-1:0] readData;
        logic                 acked;
        wishboneAccess(1'b0, adr, '0, readData, acked);
        if (acked) begin
            readChecks++;
            assert (readData === expected) else begin
                $display("FAILED at %0t ns: word %0d expected %0d, read %0d",
                         $time, adr, expected, readData);
                compareErrors++;
            end
        end
    endtask

    // token based, so several operations may share a line
    task automatic replayPatterns(input int fd);
        logic [7:0]       opChar;
        logic [8*128-1:0] restOfLine;
        int               fieldA;
        int               fieldB;
        int               fieldsWanted;
        int               scanCode;
        int               opCount;
        logic             done;
        opCount = 0;
        done    = 1'b0;
        while (!done && opCount < maxOps) begin
            opChar   = 8'h00;
            scanCode = $fscanf(fd, "%s", opChar);
            if (scanCode != 1) begin
                done = 1'b1;
            end else if (opChar == "#") begin
                scanCode = $fgets(restOfLine, fd);
            end else begin
                opCount++;
                fieldsWanted = (opChar == "S" || opChar == "I") ? 1 :
                               (opChar == "W" || opChar == "R") ? 2 : 0;
                if (fieldsWanted == 0) begin
                    $display("unknown opcode '%s' in the pattern file", opChar);
                    otherErrors++;
                    done = 1'b1;
                end else begin
                    if (fieldsWanted == 1) begin
                        scanCode = $fscanf(fd, "%d", fieldA);
                    end else begin
                        scanCode = $fscanf(fd, "%d %d", fieldA, fieldB);
                    end
                    if (scanCode != fieldsWanted) begin
                        $display("pattern file ends inside a '%s' operation", opChar);
                        otherErrors++;
                        done = 1'b1;
                    end else begin
                        case (opChar)
                            "S":     offerSample(PixelWidth'(fieldA));
                            "I":     idleCycle(PixelWidth'(fieldA));
                            "W":     writeRegister(8'(fieldA), DataWidth'(fieldB));
                            default: checkRead(8'(fieldA), DataWidth'(fieldB));
                        endcase
                    end
                end
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        arstN         = 1'b0;
        sampleIn      = '0;
        wbCyc         = 1'b0;
        wbStb         = 1'b0;
        wbWe          = 1'b0;
        wbAdr         = '0;
        wbDatW        = '0;
        readChecks    = 0;
        compareErrors = 0;
        timeoutErrors = 0;
        otherErrors   = 0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);

        patternFd = $fopen("dv/hisPatterns.txt", "r");
        if (patternFd == 0) begin
            $display("could not open the pattern file dv/hisPatterns.txt");
            otherErrors++;
        end else begin
            replayPatterns(patternFd);
            $fclose(patternFd);
        end

        $display("%0d reads checked, %0d compare errors, %0d timeouts, %0d other errors",
                 readChecks, compareErrors, timeoutErrors, otherErrors);
        if (compareErrors + timeoutErrors + otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/hisPatterns.txt ====
# opcode then decimal fields, several operations may share a line
# S value = sample beat, I value = idle beat, W addr data = write, R addr expected = read
# idle after reset, none of these beats count
S 108  S 511  S 1022  S 1022
S 200  S 90   S 511   S 1023
S 90   S 90   S 90    S 90
R 1 0  R 2 1023  R 3 0  R 4 0
R 16 0  R 17 0  R 18 0  R 19 0
R 20 0  R 21 0  R 22 0  R 23 0
# start, then the same acquisition
W 0 1  R 1 1
S 108  S 511  S 1022  S 1022
S 200  S 90   S 511   S 1023
# an idle beat of 0 must not touch the minimum
I 0
S 90   S 90   S 90    S 90
# bin is value / 128
R 16 6  R 17 1  R 18 0  R 19 2
R 20 0  R 21 0  R 22 0  R 23 3
R 2 90  R 3 1023  R 4 12  R 1 1
# stop, a further beat of 0 is ignored
W 0 2  S 0
R 2 90  R 3 1023  R 4 12  R 1 0
R 16 6
# clear while stopped
W 0 3
R 1 0  R 2 1023  R 3 0  R 4 0
R 16 0  R 17 0  R 18 0  R 19 0
R 20 0  R 21 0  R 22 0  R 23 0
# second acquisition
W 0 1
S 300  S 500  S 50   S 1000
S 48   S 90   S 600  S 500
S 1000 S 1023 S 120  S 90
R 16 5  R 17 0  R 18 1  R 19 2
R 20 1  R 21 0  R 22 0  R 23 3
R 2 48  R 3 1023  R 4 12  R 1 1
# register map edges, data 7 is no command
R 0 0  R 24 0  R 200 0
W 0 7  R 1 1
W 0 2  W 0 7  R 1 0

// ==== vlog.f ====
rtl/hisPkg.sv
rtl/hisBinCounter.sv
rtl/hisRangeTracker.sv
rtl/hisReadout.sv
rtl/hisBuilderTop.sv
dv/hisBuilderTb.sv

// ==== Bender.yml ====
package:
  name: hisBuilder

sources:
  - files:
      - rtl/hisPkg.sv
      - rtl/hisBinCounter.sv
      - rtl/hisRangeTracker.sv
      - rtl/hisReadout.sv
      - rtl/hisBuilderTop.sv
  - target: test
    files:
      - dv/hisBuilderTb.sv
